//--- verilog/cmpr_macros.svh
`ifndef CMPR_MACROS_SVH
`define CMPR_MACROS_SVH

// data path
`define CMPR_BEAT_W     64   // bits per read beat
`define CMPR_PAGE_BEATS 32   // single-beat reads per page
`define CMPR_PAGE_BYTES 256  // one way holds one page

// zspage layout
`define CMPR_ZS_OFFSET  16   // metadata bytes at the front of a zspage way
`define CMPR_HDR_BYTES  4    // header in front of every compressed page
`define CMPR_CLASSES    4    // under-construction table rows

// address fields
`define CMPR_WAY_W      20   // way number
`define CMPR_ADDR_W     32   // byte address
`define CMPR_ATT_W      10   // address translation entry id

// way number to byte address shift, page is a power of two
`define CMPR_WAY_SHIFT  $clog2(`CMPR_PAGE_BYTES)

`endif

//--- verilog/cmpr_pkg.sv
`include "cmpr_macros.svh"

package cmpr_pkg;

    typedef logic [`CMPR_ADDR_W-1:0] addr_t;  // byte address
    typedef logic [`CMPR_WAY_W-1:0]  way_t;   // way number, base = way * page bytes
    typedef logic [`CMPR_ATT_W-1:0]  att_id_t;
    typedef logic [9:0]              csize_t; // compressed size in bytes
    typedef logic [1:0]              class_t; // size class index
    typedef logic [`CMPR_BEAT_W-1:0] beat_t;

    typedef enum logic [1:0] {
        uncomp  = 2'd0,
        ifl     = 2'd1,   // isolated free list, new zspage
        nullify = 2'd2    // page moved into an open zspage
    } list_t;

    typedef enum logic [3:0] {
        st_idle, st_peek_head, st_head_wait, st_decode, st_burst_read,
        st_comp_wait, st_class_lookup, st_page_write, st_tbl_update,
        st_done, st_error
    } mngr_state_t;

    // low bits of the head beat
    typedef struct packed {
        way_t    way;
        att_id_t att_id;
    } list_entry_t;

    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic       rvalid;
        logic [1:0] rresp;  // nonzero means bus error
        beat_t      rdata;
    } rd_resp_t;

    typedef struct packed {
        logic   update;       // level, held until zspg_updated
        way_t   iway;         // zspage way
        addr_t  cpage_start;
        csize_t cpage_size;
        logic   new_zspage;
    } pg_wr_t;

    typedef struct packed {
        logic    tbl_update;  // level, held until tbl_update_done
        att_id_t att_id;
        addr_t   new_addr;    // byte address of the compressed page
        list_t   src_list;
        list_t   dst_list;
        class_t  size_class;
    } tbl_upd_t;

    // class = size * 4 / page bytes
    function automatic class_t get_class(csize_t size);
        logic [11:0] scaled;
        scaled = {size, 2'b00};
        return class_t'(scaled / `CMPR_PAGE_BYTES);
    endfunction

    function automatic addr_t way_base(way_t way);
        return addr_t'(way) << `CMPR_WAY_SHIFT;
    endfunction

endpackage

//--- verilog/rd_fifo.sv
`timescale 1ns/1ns
`include "cmpr_macros.svh"

module rd_fifo (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              wr_en,
    input  cmpr_pkg::beat_t   wr_data,
    input  logic              rd_en,
    input  logic              ptr_rst,   // sync clear of pointers and count
    output cmpr_pkg::beat_t   rd_data,
    output logic              full,
    output logic              empty
);

    localparam int unsigned DEPTH = `CMPR_PAGE_BEATS;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    cmpr_pkg::beat_t  mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             do_wr, do_rd;

    assign full    = (cnt_q == CNT_W'(DEPTH));
    assign empty   = (cnt_q == '0);
    assign do_wr   = wr_en && !full;   // drop writes when full
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr_q];    // show-ahead read

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (ptr_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_wr) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (do_rd) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (do_wr && !do_rd) cnt_q <= cnt_q + 1'b1;
            else if (do_rd && !do_wr) cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) mem[wr_ptr_q] <= wr_data;
    end

endmodule

//--- verilog/page_compressor.sv
`timescale 1ns/1ns
`include "cmpr_macros.svh"

module page_compressor (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             start,     // one-cycle, FIFO holds a full page
    input  logic             empty,
    input  cmpr_pkg::beat_t  rd_data,
    output logic             rd_en,
    output logic             done,
    output cmpr_pkg::csize_t size
);

    localparam int unsigned CNT_W = $clog2(`CMPR_PAGE_BEATS + 1);

    typedef enum logic {
        cs_idle,
        cs_drain
    } comp_state_t;

    comp_state_t      st_q;
    logic [CNT_W-1:0] nz_cnt_q;   // nonzero beats seen so far

    // zero-word elimination
    // a zero beat costs nothing, a nonzero beat is stored whole,
    // and the header carries the presence bitmap
    assign rd_en = (st_q == cs_drain) && !empty;
    assign done  = (st_q == cs_drain) && empty;   // one cycle, state leaves drain
    assign size  = cmpr_pkg::csize_t'(`CMPR_HDR_BYTES)
                 + (cmpr_pkg::csize_t'(nz_cnt_q) << $clog2(`CMPR_BEAT_W / 8));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st_q     <= cs_idle;
            nz_cnt_q <= '0;
        end else begin
            case (st_q)
                cs_idle: begin
                    if (start) begin
                        nz_cnt_q <= '0;   // new page
                        st_q     <= cs_drain;
                    end
                end
                cs_drain: begin
                    if (rd_en && (rd_data != '0)) nz_cnt_q <= nz_cnt_q + 1'b1;
                    if (empty) st_q <= cs_idle;   // size reported this cycle
                end
                default: st_q <= cs_idle;
            endcase
        end
    end

endmodule

//--- verilog/cmpr_mngr.sv
`timescale 1ns/1ns
`include "cmpr_macros.svh"

module cmpr_mngr (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               trigger,
    input  cmpr_pkg::addr_t    list_head_addr,
    input  logic               arready,
    input  cmpr_pkg::rd_resp_t rd_resp,
    input  logic               fifo_full,
    input  logic               comp_done,
    input  cmpr_pkg::csize_t   comp_size,
    input  logic               pg_wr_ready,
    input  logic               zspg_updated,
    input  logic               tbl_update_done,
    output cmpr_pkg::rd_req_t  rd_req,
    output logic               arvalid,
    output logic               burst_active,
    output logic               fifo_rst,
    output logic               comp_start,
    output cmpr_pkg::pg_wr_t   pg_wr,
    output cmpr_pkg::tbl_upd_t tbl_upd,
    output logic               cmpr_done,
    output cmpr_pkg::way_t     free_way,
    output logic               cmpr_error
);

    localparam int unsigned BCNT_W  = $clog2(`CMPR_PAGE_BEATS + 1);
    localparam int unsigned ENTRY_W = $bits(cmpr_pkg::list_entry_t);

    // control
    cmpr_pkg::mngr_state_t    st_q;
    logic                     pending_q;   // one read in flight
    logic [BCNT_W-1:0]        burst_cnt_q; // beats requested
    logic                     pg_upd_q;
    logic                     tbl_upd_q;
    logic [`CMPR_CLASSES-1:0] uc_valid_q;  // open zspage per class

    // payload
    cmpr_pkg::addr_t          rd_addr_q;
    logic [ENTRY_W-1:0]       head_raw_q;
    cmpr_pkg::list_entry_t    entry_q;
    cmpr_pkg::csize_t         csize_q;
    cmpr_pkg::class_t         cls_q;
    cmpr_pkg::way_t           pw_iway_q;
    cmpr_pkg::addr_t          pw_start_q;
    logic                     pw_new_q;
    cmpr_pkg::list_t          dst_q;
    cmpr_pkg::way_t           uc_way_q    [`CMPR_CLASSES];
    cmpr_pkg::addr_t          uc_cursor_q [`CMPR_CLASSES];  // next free byte in the open way

    logic                     rd_issue;
    logic                     rd_err;
    cmpr_pkg::addr_t          beat_addr;
    cmpr_pkg::class_t         lk_cls;
    cmpr_pkg::addr_t          lk_end;
    cmpr_pkg::addr_t          new_start;
    logic                     lk_fits;
    logic                     lk_too_big;

    assign rd_issue  = arready && !arvalid && !pending_q;
    assign rd_err    = rd_resp.rvalid && (rd_resp.rresp != '0);
    assign beat_addr = cmpr_pkg::way_base(entry_q.way)
                     + (cmpr_pkg::addr_t'(burst_cnt_q) << $clog2(`CMPR_BEAT_W / 8));

    // class lookup, all from the registered size
    assign lk_cls     = cmpr_pkg::get_class(csize_q);
    assign lk_end     = cmpr_pkg::way_base(uc_way_q[lk_cls]) + `CMPR_PAGE_BYTES;
    assign lk_fits    = uc_valid_q[lk_cls]
                     && (uc_cursor_q[lk_cls] + cmpr_pkg::addr_t'(csize_q) <= lk_end);
    assign lk_too_big = (11'(csize_q) + 11'(`CMPR_ZS_OFFSET)) >= 11'(`CMPR_PAGE_BYTES);
    assign new_start  = cmpr_pkg::way_base(entry_q.way) + `CMPR_ZS_OFFSET;  // past metadata

    assign rd_req       = '{addr: rd_addr_q};
    assign burst_active = (st_q == cmpr_pkg::st_burst_read);
    assign comp_start   = burst_active && fifo_full;    // pulse, state moves on
    assign cmpr_done    = (st_q == cmpr_pkg::st_done);
    assign free_way     = entry_q.way;                  // the joined page's own way
    assign cmpr_error   = (st_q == cmpr_pkg::st_error);

    assign pg_wr = '{update:      pg_upd_q,
                     iway:        pw_iway_q,
                     cpage_start: pw_start_q,
                     cpage_size:  csize_q,
                     new_zspage:  pw_new_q};

    assign tbl_upd = '{tbl_update: tbl_upd_q,
                       att_id:     entry_q.att_id,
                       new_addr:   pw_start_q,
                       src_list:   cmpr_pkg::uncomp,
                       dst_list:   dst_q,
                       size_class: cls_q};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st_q        <= cmpr_pkg::st_idle;
            arvalid     <= 1'b0;
            pending_q   <= 1'b0;
            burst_cnt_q <= '0;
            fifo_rst    <= 1'b0;
            pg_upd_q    <= 1'b0;
            tbl_upd_q   <= 1'b0;
            uc_valid_q  <= '0;    // table empty
        end else begin
            arvalid  <= 1'b0;     // single-cycle pulses
            fifo_rst <= 1'b0;
            if (rd_resp.rvalid) pending_q <= 1'b0;
            case (st_q)
                cmpr_pkg::st_idle: begin
                    if (trigger) st_q <= cmpr_pkg::st_peek_head;
                end
                cmpr_pkg::st_peek_head: begin
                    if (rd_issue) begin   // read head entry of the uncompressed list
                        arvalid   <= 1'b1;
                        pending_q <= 1'b1;
                        st_q      <= cmpr_pkg::st_head_wait;
                    end
                end
                cmpr_pkg::st_head_wait: begin
                    if (rd_resp.rvalid) begin
                        st_q <= rd_err ? cmpr_pkg::st_error : cmpr_pkg::st_decode;
                    end
                end
                cmpr_pkg::st_decode: begin
                    burst_cnt_q <= '0;
                    st_q        <= cmpr_pkg::st_burst_read;
                end
                cmpr_pkg::st_burst_read: begin
                    if (rd_err) begin
                        st_q <= cmpr_pkg::st_error;
                    end else if (fifo_full) begin
                        st_q <= cmpr_pkg::st_comp_wait;       // comp_start goes out now
                    end else if (rd_issue && (burst_cnt_q < BCNT_W'(`CMPR_PAGE_BEATS))) begin
                        arvalid     <= 1'b1;
                        pending_q   <= 1'b1;
                        burst_cnt_q <= burst_cnt_q + 1'b1;
                    end
                end
                cmpr_pkg::st_comp_wait: begin
                    if (comp_done) begin
                        fifo_rst <= 1'b1;
                        st_q     <= cmpr_pkg::st_class_lookup;
                    end
                end
                cmpr_pkg::st_class_lookup: begin
                    if (lk_too_big) begin
                        st_q <= cmpr_pkg::st_error;         // no room even in an empty way
                    end else begin
                        if (!lk_fits) uc_valid_q[lk_cls] <= 1'b1;   // open a new zspage
                        st_q <= cmpr_pkg::st_page_write;
                    end
                end
                cmpr_pkg::st_page_write: begin
                    if (zspg_updated) begin
                        pg_upd_q <= 1'b0;
                        st_q     <= cmpr_pkg::st_tbl_update;
                    end else if (pg_wr_ready) begin
                        pg_upd_q <= 1'b1;                   // held once raised
                    end
                end
                cmpr_pkg::st_tbl_update: begin
                    if (tbl_update_done) begin
                        tbl_upd_q <= 1'b0;
                        // a joined page frees its way, a new zspage takes the next entry
                        st_q <= (dst_q == cmpr_pkg::nullify) ? cmpr_pkg::st_done
                                                             : cmpr_pkg::st_peek_head;
                    end else if (pg_wr_ready) begin
                        tbl_upd_q <= 1'b1;
                    end
                end
                cmpr_pkg::st_done:  st_q <= cmpr_pkg::st_idle;
                cmpr_pkg::st_error: st_q <= cmpr_pkg::st_error;   // sticky
                default:            st_q <= cmpr_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (st_q)
            cmpr_pkg::st_peek_head: begin
                if (rd_issue) rd_addr_q <= list_head_addr;
            end
            cmpr_pkg::st_head_wait: begin
                if (rd_resp.rvalid) head_raw_q <= rd_resp.rdata[ENTRY_W-1:0];
            end
            cmpr_pkg::st_decode: entry_q <= cmpr_pkg::list_entry_t'(head_raw_q);
            cmpr_pkg::st_burst_read: begin
                if (rd_issue) rd_addr_q <= beat_addr;
            end
            cmpr_pkg::st_comp_wait: begin
                if (comp_done) csize_q <= comp_size;
            end
            cmpr_pkg::st_class_lookup: begin
                cls_q <= lk_cls;
                if (lk_fits) begin                        // join at the cursor
                    pw_iway_q           <= uc_way_q[lk_cls];
                    pw_start_q          <= uc_cursor_q[lk_cls];
                    pw_new_q            <= 1'b0;
                    dst_q               <= cmpr_pkg::nullify;
                    uc_cursor_q[lk_cls] <= uc_cursor_q[lk_cls] + cmpr_pkg::addr_t'(csize_q);
                end else if (!lk_too_big) begin           // own way becomes the zspage
                    pw_iway_q           <= entry_q.way;
                    pw_start_q          <= new_start;
                    pw_new_q            <= 1'b1;
                    dst_q               <= cmpr_pkg::ifl;
                    uc_way_q[lk_cls]    <= entry_q.way;
                    uc_cursor_q[lk_cls] <= new_start + cmpr_pkg::addr_t'(csize_q);
                end
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/cmpr_top.sv
`timescale 1ns/1ns

module cmpr_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               trigger,
    input  cmpr_pkg::addr_t    list_head_addr,
    input  logic               arready,
    input  cmpr_pkg::rd_resp_t rd_resp,
    output cmpr_pkg::rd_req_t  rd_req,
    output logic               arvalid,
    input  logic               pg_wr_ready,
    input  logic               zspg_updated,
    output cmpr_pkg::pg_wr_t   pg_wr,
    input  logic               tbl_update_done,
    output cmpr_pkg::tbl_upd_t tbl_upd,
    output logic               cmpr_done,
    output cmpr_pkg::way_t     free_way,
    output logic               cmpr_error
);

    logic             burst_active, fifo_rst, fifo_wr_en, fifo_rd_en;
    logic             fifo_full, fifo_empty;
    logic             comp_start, comp_done;
    cmpr_pkg::beat_t  fifo_rd_data;
    cmpr_pkg::csize_t comp_size;

    assign fifo_wr_en = burst_active && rd_resp.rvalid;  // head reads stay out of the FIFO

    cmpr_mngr i_mngr (
        .clk_i, .rst_ni, .trigger, .list_head_addr, .arready, .rd_resp,
        .fifo_full, .comp_done, .comp_size, .pg_wr_ready, .zspg_updated,
        .tbl_update_done, .rd_req, .arvalid, .burst_active, .fifo_rst,
        .comp_start, .pg_wr, .tbl_upd, .cmpr_done, .free_way, .cmpr_error
    );

    rd_fifo i_fifo (
        .clk_i, .rst_ni,
        .wr_en   (fifo_wr_en),
        .wr_data (rd_resp.rdata),
        .rd_en   (fifo_rd_en),
        .ptr_rst (fifo_rst),
        .rd_data (fifo_rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    page_compressor i_comp (
        .clk_i, .rst_ni,
        .start   (comp_start),
        .empty   (fifo_empty),
        .rd_data (fifo_rd_data),
        .rd_en   (fifo_rd_en),
        .done    (comp_done),
        .size    (comp_size)
    );

endmodule

//--- test/cmpr_sva.sv
`timescale 1ns/1ns

module cmpr_sva (
    input logic             clk_i,
    input logic             rst_ni,
    input logic             arready,
    input logic             arvalid,
    input cmpr_pkg::pg_wr_t pg_wr,
    input logic             zspg_updated,
    input logic             cmpr_done,
    input logic             cmpr_error
);

    // single-beat read request, issued only after arready was seen high
    a_arvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        arvalid |=> !arvalid) else $error("arvalid held longer than one cycle");
    a_arvalid_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        arvalid |-> $past(arready)) else $error("arvalid issued while arready low");

    // page write level stays up until the write manager answers
    a_pg_wr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pg_wr.update && !zspg_updated |=> pg_wr.update)
        else $error("pg_wr.update dropped before zspg_updated");

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmpr_done |=> !cmpr_done) else $error("cmpr_done longer than one cycle");

    // error state is sticky, only reset clears it
    a_error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmpr_error |=> cmpr_error) else $error("cmpr_error cleared without reset");

endmodule

bind cmpr_top cmpr_sva i_sva (.*);

//--- test/cmpr_tb.sv
`timescale 1ns/1ns
`include "cmpr_macros.svh"

module cmpr_tb;

    localparam int unsigned NROWS     = 6;
    localparam int unsigned NENT      = 11;
    localparam logic [31:0] HEAD_BASE = 32'h0010_0000;  // list entries live above the pages
    localparam int unsigned CYC_PAGE  = 64 + `CMPR_PAGE_BEATS * 8;  // worst case per page
    localparam longint      WDOG_NS   = longint'(NROWS * 4 * CYC_PAGE + NROWS * 20) * 40;

    typedef struct packed {
        int   first;      // first list entry of the row
        int   cnt;        // entries consumed before cmpr_done
        logic inj_err;    // nonzero rresp on page beats
        logic exp_err;
        int   exp_free;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni, trigger, arready, arvalid, pg_wr_ready, zspg_updated;
    logic tbl_update_done, cmpr_done, cmpr_error;
    cmpr_pkg::addr_t    list_head_addr;
    cmpr_pkg::rd_resp_t rd_resp;
    cmpr_pkg::rd_req_t  rd_req;
    cmpr_pkg::pg_wr_t   pg_wr;
    cmpr_pkg::tbl_upd_t tbl_upd;
    cmpr_pkg::way_t     free_way;

    int   ent_way [NENT] = '{'h10, 'h11, 'h12, 'h20, 'h21, 'h22, 'h23, 'h30, 'h31, 'h40, 'h41};
    int   ent_nz  [NENT] = '{5, 3, 0, 17, 28, 10, 12, 5, 32, 2, 1};  // nonzero beats per page
    row_t rows    [NROWS];
    int   errors, cur_pos, done_cnt;
    logic inject_err;
    // reference zspage table, per class
    logic mdl_valid [`CMPR_CLASSES];
    int   mdl_way [`CMPR_CLASSES];
    int   mdl_cur [`CMPR_CLASSES];
    int   exp_start, exp_cls;
    logic exp_new;    // current page opens a new zspage

    cmpr_top i_dut (.*);

    always #20 clk_i = ~clk_i;

    task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int nz_of_way(int way);
        int n;
        n = 0;
        for (int i = 0; i < NENT; i++) if (ent_way[i] == way) n = ent_nz[i];
        return n;
    endfunction

    task automatic apply_reset();
        rst_ni <= 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int c = 0; c < `CMPR_CLASSES; c++) mdl_valid[c] = 1'b0;  // table empty again
    endtask

    // memory: one response per request, 1 to 4 cycles later
    initial begin : mem_model
        logic [31:0] a;
        logic [63:0] d;
        int          idx;
        int          beat_idx;   // next page beat expected for the current entry
        forever begin
            @(posedge clk_i);
            if (rst_ni && arvalid) begin
                a = rd_req.addr;
                if (a >= HEAD_BASE) begin
                    check_eq("rd_req.addr", 64'(a), 64'(HEAD_BASE + 32'(8 * cur_pos)));
                    beat_idx = 0;
                    idx = int'((a - HEAD_BASE) >> 3);
                    d = 64'(cmpr_pkg::list_entry_t'{way: cmpr_pkg::way_t'(ent_way[idx]),
                                                     att_id: cmpr_pkg::att_id_t'('h100 + idx)});
                end else begin
                    // beats come in order from the entry's own way
                    check_eq("rd_req.addr", 64'(a),
                             64'(ent_way[cur_pos] * `CMPR_PAGE_BYTES + 8 * beat_idx));
                    beat_idx++;
                    // beat index below the nonzero count carries an address pattern
                    d = (int'(a[7:3]) < nz_of_way(int'(a >> 8))) ? {a, ~a} : 64'h0;
                end
                repeat ($urandom_range(0, 3)) @(posedge clk_i);
                rd_resp <= '{rvalid: 1'b1, rresp: (inject_err && a < HEAD_BASE) ? 2'd2 : 2'd0,
                             rdata: d};
                @(posedge clk_i);
                rd_resp <= '0;
            end
        end
    end

    // page write manager, predicts placement from the class rule
    initial begin : pg_writer
        int sz;
        int cls;
        logic fits;
        forever begin
            @(posedge clk_i);
            if (rst_ni && pg_wr.update) begin
                sz   = `CMPR_HDR_BYTES + 8 * ent_nz[cur_pos];
                cls  = sz * 4 / `CMPR_PAGE_BYTES;
                fits = mdl_valid[cls]
                    && (mdl_cur[cls] + sz <= mdl_way[cls] * `CMPR_PAGE_BYTES + `CMPR_PAGE_BYTES);
                exp_new = !fits;
                check_eq("pg_wr.new_zspage", 64'(pg_wr.new_zspage), 64'(exp_new));
                check_eq("pg_wr.cpage_size", 64'(pg_wr.cpage_size), 64'(sz));
                if (fits) begin   // join at the cursor
                    exp_start = mdl_cur[cls];
                    check_eq("pg_wr.iway", 64'(pg_wr.iway), 64'(mdl_way[cls]));
                end else begin    // own way starts a zspage
                    exp_start      = ent_way[cur_pos] * `CMPR_PAGE_BYTES + `CMPR_ZS_OFFSET;
                    mdl_valid[cls] = 1'b1;
                    mdl_way[cls]   = ent_way[cur_pos];
                    check_eq("pg_wr.iway", 64'(pg_wr.iway), 64'(ent_way[cur_pos]));
                end
                mdl_cur[cls] = exp_start + sz;
                exp_cls      = cls;
                check_eq("pg_wr.cpage_start", 64'(pg_wr.cpage_start), 64'(exp_start));
                repeat ($urandom_range(0, 2)) @(posedge clk_i);
                zspg_updated <= 1'b1;
                @(posedge clk_i);
                zspg_updated <= 1'b0;
            end
        end
    end

    // list and table manager, advances the head on completion
    initial begin : tbl_writer
        cmpr_pkg::list_t dst;
        forever begin
            @(posedge clk_i);
            if (rst_ni && tbl_upd.tbl_update) begin
                dst = exp_new ? cmpr_pkg::ifl : cmpr_pkg::nullify;
                check_eq("tbl_upd.att_id", 64'(tbl_upd.att_id), 64'('h100 + cur_pos));
                check_eq("tbl_upd.new_addr", 64'(tbl_upd.new_addr), 64'(exp_start));
                check_eq("tbl_upd.src_list", 64'(tbl_upd.src_list), 64'(cmpr_pkg::uncomp));
                check_eq("tbl_upd.dst_list", 64'(tbl_upd.dst_list), 64'(dst));
                check_eq("tbl_upd.size_class", 64'(tbl_upd.size_class), 64'(exp_cls));
                repeat ($urandom_range(0, 2)) @(posedge clk_i);
                tbl_update_done <= 1'b1;
                list_head_addr  <= list_head_addr + 8;
                cur_pos++;
                done_cnt++;
                @(posedge clk_i);
                tbl_update_done <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WDOG_NS);
        $display("timeout, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        int err_before;
        int free_seen;
        void'($urandom(17));
        rst_ni = 1'b0;
        trigger = 1'b0;
        arready = 1'b1;
        pg_wr_ready = 1'b1;
        zspg_updated = 1'b0;
        tbl_update_done = 1'b0;
        rd_resp = '0;
        inject_err = 1'b0;
        list_head_addr = HEAD_BASE;
        errors = 0;
        // first, count, rresp injection, error expected, freed way
        rows[0] = '{0, 2, 1'b0, 1'b0, 'h11};  // same class, second joins
        rows[1] = '{2, 1, 1'b0, 1'b0, 'h12};  // empty page joins open class 0
        rows[2] = '{3, 4, 1'b0, 1'b0, 'h23};  // classes 2, 3, 1 open, then class 1 joins
        rows[3] = '{7, 0, 1'b1, 1'b1, 0};     // bus error on a page beat
        rows[4] = '{8, 0, 1'b0, 1'b1, 0};     // all beats nonzero, too large
        rows[5] = '{9, 2, 1'b0, 1'b0, 'h41};  // table must be empty after reset
        apply_reset();
        @(negedge clk_i);
        check_eq("arvalid", 64'(arvalid), 0);
        check_eq("comp_start", 64'(i_dut.comp_start), 0);
        check_eq("pg_wr.update", 64'(pg_wr.update), 0);
        check_eq("tbl_upd.tbl_update", 64'(tbl_upd.tbl_update), 0);
        check_eq("cmpr_done", 64'(cmpr_done), 0);
        check_eq("cmpr_error", 64'(cmpr_error), 0);
        for (int r = 0; r < NROWS; r++) begin
            err_before = errors;
            @(posedge clk_i);
            cur_pos    = rows[r].first;
            done_cnt   = 0;
            inject_err = rows[r].inj_err;
            list_head_addr <= HEAD_BASE + 32'(8 * rows[r].first);
            trigger        <= 1'b1;
            @(posedge clk_i);
            trigger <= 1'b0;
            @(negedge clk_i);
            check_eq("arvalid", 64'(arvalid), 0);
            @(negedge clk_i);
            check_eq("arvalid", 64'(arvalid), 1);   // 2 cycles after trigger
            while (!cmpr_done && !cmpr_error) @(negedge clk_i);
            free_seen = int'(free_way);
            if (rows[r].exp_err) begin
                check_eq("cmpr_error", 64'(cmpr_error), 1);
                repeat (8) begin
                    @(negedge clk_i);
                    check_eq("cmpr_done", 64'(cmpr_done), 0);
                    check_eq("cmpr_error", 64'(cmpr_error), 1);
                end
                @(posedge clk_i);
                apply_reset();
                @(negedge clk_i);
                check_eq("cmpr_error", 64'(cmpr_error), 0);
            end else begin
                check_eq("cmpr_error", 64'(cmpr_error), 0);
                check_eq("free_way", 64'(free_seen), 64'(rows[r].exp_free));
                check_eq("pages per trigger", 64'(done_cnt), 64'(rows[r].cnt));
            end
            $display("test %0d: %s", r, (errors == err_before) ? "ok" : "failed");
        end
        $display("%0d tests run, %0d errors", NROWS, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/cmpr_pkg.sv
verilog/rd_fifo.sv
verilog/page_compressor.sv
verilog/cmpr_mngr.sv
verilog/cmpr_top.sv
test/cmpr_sva.sv
test/cmpr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the compaction engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --assert \
    --top-module cmpr_tb -f vlog.f -o cmpr_sim

./obj_dir/cmpr_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"
